// File: logic/panel_pkg.sv
`default_nettype none

package panel_pkg;

   // number of seven-segment digits on the board.
   localparam int digits = 4;

   // index width for the digit scan.
   localparam int idx_w = $clog2(digits);

   // samples of both reset buttons before the request rises.
   localparam int hold_ticks = 8;

   // counter width, wide enough to hold hold_ticks itself.
   localparam int hold_cnt_w = $clog2(hold_ticks + 1);

   // selector codes taken from the upper switch nibble.
   localparam logic [3:0] sel_port_a = 4'd0;
   localparam logic [3:0] sel_port_b = 4'd1;
   localparam logic [3:0] sel_port_c = 4'd2;
   localparam logic [3:0] sel_port_d = 4'd3;
   localparam logic [3:0] sel_inputs = 4'd4;
   localparam logic [3:0] sel_direct = 4'd10;

   // segment bytes are dp g f e d c b a, bit 7 is the decimal point.
   localparam logic [7:0] font_dash = 8'b0100_0000;

   // one display word, read as hex nibbles or as raw segment bytes.
   typedef union packed
   {
      logic [2*digits-1:0][3:0] hex;
      logic [digits-1:0][7:0]   raw;
   } display_word_u;

endpackage : panel_pkg

`default_nettype wire

// File: logic/btn_reset.sv
`timescale 1ns/1ps
`default_nettype none

module btn_reset
   import panel_pkg::*;
(
   input  logic f100Hz,
   input  logic rst_n,
   input  logic b0,
   input  logic b1,
   output logic res_req
);

   logic                  b0_q;
   logic                  b1_q;
   logic [hold_cnt_w-1:0] hold_cnt;

   // own sample of the two buttons.
   always_ff @(posedge f100Hz or negedge rst_n)
   begin
      if (!rst_n)
      begin
         b0_q <= 1'b0;
         b1_q <= 1'b0;
      end
      else
      begin
         b0_q <= b0;
         b1_q <= b1;
      end
   end

   // count samples with both buttons held, saturating at hold_ticks.
   always_ff @(posedge f100Hz or negedge rst_n)
   begin
      if (!rst_n)
      begin
         hold_cnt <= '0;
         res_req  <= 1'b0;
      end
      else if (b0_q && b1_q)
      begin
         if (hold_cnt != hold_cnt_w'(hold_ticks))
         begin
            hold_cnt <= hold_cnt + 1'b1;
         end
         // rises on the edge where the count reaches hold_ticks.
         res_req <= (hold_cnt >= hold_cnt_w'(hold_ticks - 1));
      end
      else
      begin
         hold_cnt <= '0;
         res_req  <= 1'b0;
      end
   end

endmodule : btn_reset

`default_nettype wire

// File: logic/display_select.sv
`timescale 1ns/1ps
`default_nettype none

module display_select
   import panel_pkg::*;
(
   input  logic          f100Hz,
   input  logic          rst_n,
   input  logic [7:0]    sw,
   input  logic [3:0]    btn,
   input  logic [31:0]   port_a,
   input  logic [31:0]   port_b,
   input  logic [31:0]   port_c,
   input  logic [31:0]   port_d,
   output display_word_u disp_word,
   output logic          direct
);

   logic [7:0]          sw_q;
   logic [3:0]          btn_q;
   logic [3:0]          sel;
   logic [8*digits-1:0] inputs_word;
   logic [8*digits-1:0] word_next;
   logic                direct_next;

   // slow sampling of the panel inputs.
   always_ff @(posedge f100Hz or negedge rst_n)
   begin
      if (!rst_n)
      begin
         sw_q  <= '0;
         btn_q <= '0;
      end
      else
      begin
         sw_q  <= sw;
         btn_q <= btn;
      end
   end

   assign sel = sw_q[7:4];

   // zeros on top, then buttons, then switches in the low byte.
   assign inputs_word = {{(8*digits-12){1'b0}}, btn_q, sw_q};

   always_comb
   begin
      direct_next = 1'b0;
      case (sel)
         sel_port_a: word_next = port_a;
         sel_port_b: word_next = port_b;
         sel_port_c: word_next = port_c;
         sel_port_d: word_next = port_d;
         sel_inputs: word_next = inputs_word;
         sel_direct:
         begin
            // raw segment pattern comes from port c.
            word_next   = port_c;
            direct_next = 1'b1;
         end
         default:    word_next = '0;
      endcase
   end

   // word held for a whole scan.
   always_ff @(posedge f100Hz or negedge rst_n)
   begin
      if (!rst_n)
      begin
         disp_word <= '0;
      end
      else
      begin
         disp_word <= word_next;
      end
   end

   always_ff @(posedge f100Hz or negedge rst_n)
   begin
      if (!rst_n)
      begin
         direct <= 1'b0;
      end
      else
      begin
         direct <= direct_next;
      end
   end

endmodule : display_select

`default_nettype wire

// File: logic/seg7_scan.sv
`timescale 1ns/1ps
`default_nettype none

module seg7_scan
   import panel_pkg::*;
(
   input  logic          f100Hz,
   input  logic          rst_n,
   input  display_word_u disp_word,
   input  logic          direct,
   input  logic          res_req,
   output logic [7:0]    seg,
   output logic [3:0]    an
);

   logic [idx_w-1:0] idx;
   logic [7:0]       pattern;
   logic [3:0]       digit_on;

   // hex font, active high, dp g f e d c b a.
   function automatic logic [7:0] hex_font(input logic [3:0] nib);
      logic [7:0] f;
      case (nib)
         4'h0: f = 8'h3f;
         4'h1: f = 8'h06;
         4'h2: f = 8'h5b;
         4'h3: f = 8'h4f;
         4'h4: f = 8'h66;
         4'h5: f = 8'h6d;
         4'h6: f = 8'h7d;
         4'h7: f = 8'h07;
         4'h8: f = 8'h7f;
         4'h9: f = 8'h6f;
         4'ha: f = 8'h77;
         4'hb: f = 8'h7c;
         4'hc: f = 8'h39;
         4'hd: f = 8'h5e;
         4'he: f = 8'h79;
         default: f = 8'h71;
      endcase
      return f;
   endfunction

   // pattern of the digit being drawn this cycle.
   always_comb
   begin
      if (res_req)
      begin
         pattern = font_dash;
      end
      else if (direct)
      begin
         pattern = disp_word.raw[idx];
      end
      else
      begin
         pattern = hex_font(disp_word.hex[idx]);
      end
   end

   // one hot enable for the current digit.
   assign digit_on = digits'(1) << idx;

   // pins are active low, so everything dark is all ones.
   always_ff @(posedge f100Hz or negedge rst_n)
   begin
      if (!rst_n)
      begin
         idx <= '0;
         seg <= '1;
         an  <= '1;
      end
      else
      begin
         seg <= ~pattern;
         an  <= ~digit_on;
         idx <= idx + 1'b1;
      end
   end

endmodule : seg7_scan

`default_nettype wire

// File: logic/panel_top.sv
`timescale 1ns/1ps
`default_nettype none

module panel_top
   import panel_pkg::*;
(
   input  logic        f100Hz,
   input  logic        rst_n,
   input  logic [7:0]  sw,
   input  logic [3:0]  btn,
   input  logic [31:0] port_a,
   input  logic [31:0] port_b,
   input  logic [31:0] port_c,
   input  logic [31:0] port_d,
   output logic [7:0]  seg,
   output logic [3:0]  an,
   output logic        sys_res
);

   logic          res_req;
   display_word_u disp_word;
   logic          direct;

   // buttons 0 and 1 together request a system reset.
   btn_reset btn_reset_i
   (
      .f100Hz  (f100Hz),
      .rst_n   (rst_n),
      .b0      (btn[0]),
      .b1      (btn[1]),
      .res_req (res_req)
   );

   display_select display_select_i
   (
      .f100Hz    (f100Hz),
      .rst_n     (rst_n),
      .sw        (sw),
      .btn       (btn),
      .port_a    (port_a),
      .port_b    (port_b),
      .port_c    (port_c),
      .port_d    (port_d),
      .disp_word (disp_word),
      .direct    (direct)
   );

   seg7_scan seg7_scan_i
   (
      .f100Hz    (f100Hz),
      .rst_n     (rst_n),
      .disp_word (disp_word),
      .direct    (direct),
      .res_req   (res_req),
      .seg       (seg),
      .an        (an)
   );

   assign sys_res = res_req;

endmodule : panel_top

`default_nettype wire

// File: testbench/panel_tb.sv
`timescale 1ns/1ps
`default_nettype none

module panel_tb
   import panel_pkg::*;
   ();

   localparam logic [1:0] kind_hex    = 2'd0;
   localparam logic [1:0] kind_direct = 2'd1;
   localparam logic [1:0] kind_zero   = 2'd2;
   localparam logic [1:0] kind_dash   = 2'd3;
   localparam int         n_rows      = 12;

   typedef struct packed
   {
      logic [3:0] sel;
      logic [3:0] btn;
      int         hold;
      logic [1:0] kind;
   } row_t;

   logic        f100Hz;
   logic        rst_n;
   logic [7:0]  sw;
   logic [3:0]  btn;
   logic [31:0] port_a;
   logic [31:0] port_b;
   logic [31:0] port_c;
   logic [31:0] port_d;
   logic [7:0]  seg;
   logic [3:0]  an;
   logic        sys_res;

   row_t        rows [n_rows];
   logic [7:0]  font_tab [16];
   logic [31:0] lfsr;
   logic        prev_res;

   panel_top panel_top_i
   (
      .f100Hz  (f100Hz),
      .rst_n   (rst_n),
      .sw      (sw),
      .btn     (btn),
      .port_a  (port_a),
      .port_b  (port_b),
      .port_c  (port_c),
      .port_d  (port_d),
      .seg     (seg),
      .an      (an),
      .sys_res (sys_res)
   );

   always #20 f100Hz = ~f100Hz;

   initial
   begin
      #(n_rows * 40 * 40);
      $display("watchdog expired before the stimulus table was finished");
      $display("Result: FAILED");
      $fatal(1, "timeout");
   end

   // galois form, taps of x^32 + x^22 + x^2 + x + 1.
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
   endfunction

   task automatic take_bits(input int n, output logic [31:0] v);
      int i;
      v = '0;
      for (i = 0; i < n; i++)
      begin
         v = {v[30:0], lfsr[0]};
         lfsr = lfsr_next(lfsr);
      end
   endtask

   task automatic load_table();
      rows[0]  = '{sel_port_a, 4'b0000, 2, kind_hex};
      rows[1]  = '{sel_port_b, 4'b1000, 2, kind_hex};
      rows[2]  = '{sel_port_c, 4'b0100, 2, kind_hex};
      rows[3]  = '{sel_port_d, 4'b0000, 2, kind_hex};
      rows[4]  = '{sel_inputs, 4'b1100, 2, kind_hex};
      rows[5]  = '{sel_direct, 4'b0000, 2, kind_direct};
      rows[6]  = '{4'd7,       4'b0000, 2, kind_zero};
      rows[7]  = '{4'd15,      4'b1000, 2, kind_zero};
      rows[8]  = '{sel_port_a, 4'b0001, 20, kind_hex};
      rows[9]  = '{sel_port_c, 4'b0011, hold_ticks + 1, kind_dash};
      rows[10] = '{sel_port_b, 4'b0000, 2, kind_hex};
      rows[11] = '{sel_inputs, 4'b0110, 20, kind_hex};
   endtask

   function automatic display_word_u expected_word(input logic [3:0] sel,
      input logic [7:0] sw_v, input logic [3:0] btn_v, input logic [31:0] pa,
      input logic [31:0] pb, input logic [31:0] pc, input logic [31:0] pd);
      display_word_u w;
      case (sel)
         sel_port_a: w = pa;
         sel_port_b: w = pb;
         sel_port_c: w = pc;
         sel_port_d: w = pd;
         sel_inputs: w = {20'h0, btn_v, sw_v};
         sel_direct: w = pc;
         default:    w = '0;
      endcase
      return w;
   endfunction

   // pin level expected on one digit, active low.
   function automatic logic [7:0] expected_seg(input display_word_u w,
      input logic [1:0] kind, input logic [1:0] idx);
      logic [7:0] lit;
      if (kind == kind_dash)
         lit = font_dash;
      else if (kind == kind_direct)
         lit = w.raw[idx];
      else
         lit = font_tab[w.hex[{1'b0, idx}]];
      return ~lit;
   endfunction

   task automatic check_seg(input string what, input logic [7:0] exp, input logic [7:0] act);
      if (act !== exp)
      begin
         $display("[ERROR] %s: expected %h, actual %h", what, exp, act);
         $display("Result: FAILED");
         $fatal(1, "segment mismatch");
      end
   endtask

   task automatic check_an(input logic [3:0] exp, input logic [3:0] act);
      if (act !== exp)
      begin
         $display("[ERROR] an: expected %h, actual %h", exp, act);
         $display("Result: FAILED");
         $fatal(1, "anode mismatch");
      end
   endtask

   task automatic check_word(input display_word_u exp, input display_word_u act);
      if (act !== exp)
      begin
         $display("[ERROR] disp_word: expected %h, actual %h", exp, act);
         $display("Result: FAILED");
         $fatal(1, "display word mismatch");
      end
   endtask

   task automatic check_res(input logic exp, input logic act);
      if (act !== exp)
      begin
         $display("[ERROR] sys_res: expected %h, actual %h", exp, act);
         $display("Result: FAILED");
         $fatal(1, "reset request mismatch");
      end
   endtask

   // follow the scan until every digit has been compared once.
   task automatic check_digits(input display_word_u w, input logic [1:0] kind);
      logic [digits-1:0] seen;
      logic [3:0]        an_exp;
      logic [1:0]        idx;
      int                cycles;
      int                k;
      seen = '0;
      cycles = 0;
      while (seen != '1)
      begin
         @(negedge f100Hz);
         cycles++;
         if (cycles > 8)
         begin
            $display("the anodes did not select every digit within 8 cycles");
            $display("Result: FAILED");
            $fatal(1, "scan stalled");
         end
         for (k = 0; k < digits; k++)
         begin
            idx = k[1:0];
            an_exp = ~(4'b0001 << k);
            if (an == an_exp)
            begin
               check_seg($sformatf("seg digit %0d", k), expected_seg(w, kind, idx), seg);
               seen[idx] = 1'b1;
            end
         end
      end
   endtask

   task automatic apply_row(input row_t r);
      logic [31:0]   pa;
      logic [31:0]   pb;
      logic [31:0]   pc;
      logic [31:0]   pd;
      logic [31:0]   nib;
      logic [7:0]    sw_v;
      logic          exp_res;
      display_word_u exp_w;
      int            c;
      take_bits(32, pa);
      take_bits(32, pb);
      take_bits(32, pc);
      take_bits(32, pd);
      take_bits(4, nib);
      sw_v = {r.sel, nib[3:0]};
      exp_w = expected_word(r.sel, sw_v, r.btn, pa, pb, pc, pd);
      exp_res = prev_res;
      @(posedge f100Hz);
      port_a <= pa;
      port_b <= pb;
      port_c <= pc;
      port_d <= pd;
      sw     <= sw_v;
      btn    <= r.btn;
      for (c = 1; c <= r.hold; c++)
      begin
         @(posedge f100Hz);
         @(negedge f100Hz);
         // rises hold_ticks + 1 edges after the press, drops 2 edges after release.
         if (r.kind == kind_dash)
            exp_res = (c >= hold_ticks + 1);
         else if (c >= 2)
            exp_res = 1'b0;
         check_res(exp_res, sys_res);
      end
      prev_res = exp_res;
      repeat (8) @(posedge f100Hz);
      @(negedge f100Hz);
      check_word(exp_w, panel_top_i.disp_word);
      check_digits(exp_w, r.kind);
   endtask

   initial
   begin
      int i;
      f100Hz   = 1'b0;
      lfsr     = 32'd88238;
      prev_res = 1'b0;
      font_tab = '{8'h3f, 8'h06, 8'h5b, 8'h4f, 8'h66, 8'h6d, 8'h7d, 8'h07,
                   8'h7f, 8'h6f, 8'h77, 8'h7c, 8'h39, 8'h5e, 8'h79, 8'h71};
      load_table();
      rst_n  <= 1'b0;
      sw     <= '0;
      btn    <= '0;
      port_a <= '0;
      port_b <= '0;
      port_c <= '0;
      port_d <= '0;
      for (i = 0; i < 4; i++)
      begin
         @(negedge f100Hz);
         check_an(4'hf, an);
         check_seg("seg", 8'hff, seg);
         check_res(1'b0, sys_res);
      end
      @(posedge f100Hz);
      rst_n <= 1'b1;
      @(negedge f100Hz);
      check_an(4'hf, an);
      check_seg("seg", 8'hff, seg);
      check_res(1'b0, sys_res);
      for (i = 0; i < n_rows; i++)
         apply_row(rows[i]);
      $display("Result: PASSED");
      $finish;
   end

endmodule : panel_tb

`default_nettype wire

// File: panel.f
logic/panel_pkg.sv
logic/btn_reset.sv
logic/display_select.sv
logic/seg7_scan.sv
logic/panel_top.sv
testbench/panel_tb.sv

// File: Makefile
SRCS = $(wildcard logic/*.sv) testbench/panel_tb.sv

obj_dir/Vpanel_tb: panel.f $(SRCS)
	verilator --binary --timing --top-module panel_tb -f panel.f

.PHONY: run clean

run: obj_dir/Vpanel_tb
	./obj_dir/Vpanel_tb | awk '{ print } /Result: PASSED/ { ok = 1 } END { exit !ok }'

clean:
	rm -rf obj_dir
